/* filelist.f */
+incdir+logic
logic/rv_pkg.sv
logic/rv_mem_if.sv
logic/rv_control.sv
logic/rv_alu.sv
logic/rv_regfile.sv
logic/rv_datapath.sv
logic/rv_core_top.sv
verif/rv_core_tb.sv

/* logic/rv_alu.sv */
`timescale 1ns/1ps

module rv_alu (
	input rv_pkg::alu_op_t alu_op_i,
	input rv_pkg::cmp_op_t cmp_op_i,
	input rv_pkg::word_t din1_i,
	input rv_pkg::word_t din2_i,
	input rv_pkg::word_t cmp1_i,
	input rv_pkg::word_t cmp2_i,
	output rv_pkg::word_t dout_o,
	output logic cmp_res_o
);
	import rv_pkg::*;

	logic [4:0] shamt;

	assign shamt = din2_i[4:0];

	always_comb begin
		case (alu_op_i)
			ALU_ADD: dout_o = din1_i + din2_i;
			ALU_SUB: dout_o = din1_i - din2_i;
			ALU_SLL: dout_o = din1_i << shamt;
			ALU_SLT: dout_o = word_t'($signed(din1_i) < $signed(din2_i));
			ALU_SLTU: dout_o = word_t'(din1_i < din2_i);
			ALU_XOR: dout_o = din1_i ^ din2_i;
			ALU_SRL: dout_o = din1_i >> shamt;
			ALU_SRA: dout_o = word_t'($signed(din1_i) >>> shamt);
			ALU_OR: dout_o = din1_i | din2_i;
			ALU_AND: dout_o = din1_i & din2_i;
			default: dout_o = din2_i; // PASS2
		endcase
	end

	// Branch condition on the register operands
	always_comb begin
		case (cmp_op_i)
			CMP_EQ: cmp_res_o = (cmp1_i == cmp2_i);
			CMP_NE: cmp_res_o = (cmp1_i != cmp2_i);
			CMP_LT: cmp_res_o = ($signed(cmp1_i) < $signed(cmp2_i));
			CMP_GE: cmp_res_o = ($signed(cmp1_i) >= $signed(cmp2_i));
			CMP_LTU: cmp_res_o = (cmp1_i < cmp2_i);
			default: cmp_res_o = (cmp1_i >= cmp2_i); // GEU
		endcase
	end

endmodule

/* logic/rv_control.sv */
`timescale 1ns/1ps

module rv_control (
	input logic clk_i,
	input logic reset_i,
	input rv_pkg::word_t ir_i,
	output logic pc_we_o,
	output logic ir_we_o,
	output logic rf_we_o,
	output rv_pkg::next_pc_sel_t next_pc_sel_o,
	output rv_pkg::rf_in_sel_t rf_in_sel_o,
	output rv_pkg::rd_addr_sel_t rd_addr_sel_o,
	output logic mem_wr_en_o,
	output rv_pkg::alu_op_t alu_op_o,
	output rv_pkg::alu_in1_sel_t alu_in1_sel_o,
	output rv_pkg::alu_in2_sel_t alu_in2_sel_o,
	output rv_pkg::cmp_op_t cmp_op_o,
	output logic halted_o
);
	import rv_pkg::*;

	ctrl_state_t state;
	ctrl_state_t state_next;
	opcode_t opcode;
	logic [2:0] funct3;
	logic illegal; // ECALL or unknown opcode

	// funct3 plus the funct7 alternate bit to an ALU operation
	function automatic alu_op_t arith_op(input logic [2:0] f3, input logic alt);
		alu_op_t op;
		case (f3)
			3'b000: op = alt ? ALU_SUB : ALU_ADD;
			3'b001: op = ALU_SLL;
			3'b010: op = ALU_SLT;
			3'b011: op = ALU_SLTU;
			3'b100: op = ALU_XOR;
			3'b101: op = alt ? ALU_SRA : ALU_SRL;
			3'b110: op = ALU_OR;
			default: op = ALU_AND;
		endcase
		return op;
	endfunction

	assign opcode = opcode_t'(ir_i[6:0]);
	assign funct3 = ir_i[14:12];
	assign halted_o = (state == ST_HALT);

	always_comb begin
		pc_we_o = 1'b0;
		ir_we_o = 1'b0;
		rf_we_o = 1'b0;
		mem_wr_en_o = 1'b0;
		next_pc_sel_o = NEXT_PC_4;
		rf_in_sel_o = RF_IN_ALU_OUT;
		rd_addr_sel_o = RD_ADDR_PC;
		alu_op_o = ALU_ADD;
		alu_in1_sel_o = ALU_IN1_RS1;
		alu_in2_sel_o = ALU_IN2_IMM_I;
		cmp_op_o = CMP_EQ;
		illegal = 1'b0;
		if (state == ST_FETCH) begin
			ir_we_o = 1'b1;
		end else if (state == ST_EXECUTE) begin
			case (opcode)
				OPC_LUI: begin
					alu_op_o = ALU_PASS2;
					alu_in2_sel_o = ALU_IN2_IMM_U;
					rf_we_o = 1'b1;
				end
				OPC_AUIPC: begin
					alu_in1_sel_o = ALU_IN1_PC;
					alu_in2_sel_o = ALU_IN2_IMM_U;
					rf_we_o = 1'b1;
				end
				OPC_JAL: begin
					alu_in1_sel_o = ALU_IN1_PC;
					alu_in2_sel_o = ALU_IN2_IMM_J;
					next_pc_sel_o = NEXT_PC_ALU_OUT;
					rf_in_sel_o = RF_IN_PC_4; // Link
					rf_we_o = 1'b1;
				end
				OPC_JALR: begin
					next_pc_sel_o = NEXT_PC_ALU_OUT;
					rf_in_sel_o = RF_IN_PC_4;
					rf_we_o = 1'b1;
				end
				OPC_BRANCH: begin
					alu_in1_sel_o = ALU_IN1_PC;
					alu_in2_sel_o = ALU_IN2_IMM_B;
					next_pc_sel_o = NEXT_PC_BRANCH;
					case (funct3)
						3'b001: cmp_op_o = CMP_NE;
						3'b100: cmp_op_o = CMP_LT;
						3'b101: cmp_op_o = CMP_GE;
						3'b110: cmp_op_o = CMP_LTU;
						3'b111: cmp_op_o = CMP_GEU;
						default: cmp_op_o = CMP_EQ;
					endcase
				end
				OPC_LOAD: begin
					rd_addr_sel_o = RD_ADDR_ALU_OUT; // Data read instead of fetch
					rf_in_sel_o = RF_IN_MEM_RD;
					rf_we_o = 1'b1;
				end
				OPC_STORE: begin
					alu_in2_sel_o = ALU_IN2_IMM_S;
					mem_wr_en_o = 1'b1;
				end
				OPC_OP_IMM: begin
					alu_op_o = arith_op(funct3, ir_i[30] && (funct3 == 3'b101));
					rf_we_o = 1'b1;
				end
				OPC_OP: begin
					alu_op_o = arith_op(funct3, ir_i[30]);
					alu_in2_sel_o = ALU_IN2_RS2;
					rf_we_o = 1'b1;
				end
				default: illegal = 1'b1; // SYSTEM lands here too
			endcase
			pc_we_o = !illegal;
		end
	end

	always_comb begin
		case (state)
			ST_FETCH: state_next = ST_EXECUTE;
			ST_EXECUTE: state_next = illegal ? ST_HALT : ST_FETCH;
			default: state_next = ST_HALT;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			state <= ST_FETCH;
		end else begin
			state <= state_next;
		end
	end

	// Fetch and store never share a cycle
	assert property (@(posedge clk_i) disable iff (reset_i) !(mem_wr_en_o && ir_we_o));

	// Halt is sticky and writes nothing
	assert property (@(posedge clk_i) disable iff (reset_i)
		halted_o |=> (halted_o && !pc_we_o && !rf_we_o && !mem_wr_en_o && !ir_we_o));

endmodule

/* logic/rv_core_top.sv */
`timescale 1ns/1ps

module rv_core_top (
	input logic clk_i,
	input logic reset_i,
	output rv_pkg::word_t mem_rd_addr_o,
	input rv_pkg::word_t mem_rd_data_i,
	output rv_pkg::word_t mem_wr_addr_o,
	output rv_pkg::word_t mem_wr_data_o,
	output logic mem_wr_en_o,
	output logic halted_o
);
	import rv_pkg::*;

	rv_mem_if memif ();

	rv_datapath u_datapath (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.memif(memif.core),
		.halted_o(halted_o)
	);

	// Memory side of the bus onto plain ports
	assign mem_rd_addr_o = memif.rd_addr;
	assign memif.rd_data = mem_rd_data_i;
	assign mem_wr_addr_o = memif.wr_addr;
	assign mem_wr_data_o = memif.wr_data;
	assign mem_wr_en_o = memif.wr_enable;

endmodule

/* logic/rv_datapath.sv */
`timescale 1ns/1ps
`include "rv_settings.svh"

module rv_datapath (
	input logic clk_i,
	input logic reset_i,
	rv_mem_if.core memif,
	output logic halted_o
);
	import rv_pkg::*;

	word_t pc;
	word_t ir;
	word_t pc_plus4;
	word_t next_pc;
	word_t imm_i, imm_s, imm_b, imm_u, imm_j;
	word_t alu_din1;
	word_t alu_din2;
	word_t alu_dout;
	logic cmp_res;
	word_t rf_rin;
	word_t rf_rout1;
	word_t rf_rout2;
	reg_idx_t rs1, rs2, rd;

	logic ctrl_pc_we;
	logic ctrl_ir_we;
	logic ctrl_rf_we;
	logic ctrl_mem_wr_en;
	next_pc_sel_t ctrl_next_pc_sel;
	rf_in_sel_t ctrl_rf_in_sel;
	rd_addr_sel_t ctrl_rd_addr_sel;
	alu_op_t ctrl_alu_op;
	alu_in1_sel_t ctrl_alu_in1_sel;
	alu_in2_sel_t ctrl_alu_in2_sel;
	cmp_op_t ctrl_cmp_op;

	assign rs1 = ir[19:15];
	assign rs2 = ir[24:20];
	assign rd = ir[11:7];

	assign imm_i = {{20{ir[31]}}, ir[31:20]};
	assign imm_s = {{20{ir[31]}}, ir[31:25], ir[11:7]};
	assign imm_b = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
	assign imm_u = {ir[31:12], 12'b0};
	assign imm_j = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};

	assign pc_plus4 = pc + 4;

	rv_control u_control (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.ir_i(ir),
		.pc_we_o(ctrl_pc_we),
		.ir_we_o(ctrl_ir_we),
		.rf_we_o(ctrl_rf_we),
		.next_pc_sel_o(ctrl_next_pc_sel),
		.rf_in_sel_o(ctrl_rf_in_sel),
		.rd_addr_sel_o(ctrl_rd_addr_sel),
		.mem_wr_en_o(ctrl_mem_wr_en),
		.alu_op_o(ctrl_alu_op),
		.alu_in1_sel_o(ctrl_alu_in1_sel),
		.alu_in2_sel_o(ctrl_alu_in2_sel),
		.cmp_op_o(ctrl_cmp_op),
		.halted_o(halted_o)
	);

	rv_regfile u_regfile (
		.clk_i(clk_i),
		.rs1_i(rs1),
		.rs2_i(rs2),
		.rd_i(rd),
		.rin_i(rf_rin),
		.we_i(ctrl_rf_we),
		.rout1_o(rf_rout1),
		.rout2_o(rf_rout2)
	);

	rv_alu u_alu (
		.alu_op_i(ctrl_alu_op),
		.cmp_op_i(ctrl_cmp_op),
		.din1_i(alu_din1),
		.din2_i(alu_din2),
		.cmp1_i(rf_rout1),
		.cmp2_i(rf_rout2),
		.dout_o(alu_dout),
		.cmp_res_o(cmp_res)
	);

	always_comb begin
		alu_din1 = (ctrl_alu_in1_sel == ALU_IN1_PC) ? pc : rf_rout1;

		case (ctrl_alu_in2_sel)
			ALU_IN2_RS2: alu_din2 = rf_rout2;
			ALU_IN2_IMM_S: alu_din2 = imm_s;
			ALU_IN2_IMM_B: alu_din2 = imm_b;
			ALU_IN2_IMM_U: alu_din2 = imm_u;
			ALU_IN2_IMM_J: alu_din2 = imm_j;
			default: alu_din2 = imm_i;
		endcase

		case (ctrl_rf_in_sel)
			RF_IN_PC_4: rf_rin = pc_plus4;
			RF_IN_MEM_RD: rf_rin = memif.rd_data;
			default: rf_rin = alu_dout;
		endcase

		case (ctrl_next_pc_sel)
			NEXT_PC_ALU_OUT: next_pc = {alu_dout[31:1], 1'b0}; // JALR clears bit 0
			NEXT_PC_BRANCH: next_pc = cmp_res ? alu_dout : pc_plus4;
			default: next_pc = pc_plus4;
		endcase

		memif.rd_addr = (ctrl_rd_addr_sel == RD_ADDR_ALU_OUT) ? alu_dout : pc;
		memif.wr_addr = alu_dout;
		memif.wr_data = rf_rout2;
		memif.wr_enable = ctrl_mem_wr_en;
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			pc <= `RV_RESET_PC;
			ir <= '0;
		end else begin
			if (ctrl_pc_we) begin
				pc <= next_pc;
			end
			if (ctrl_ir_we) begin
				ir <= memif.rd_data; // Fetched word
			end
		end
	end

	// Jump and branch targets keep the PC on word boundaries
	assert property (@(posedge clk_i) disable iff (reset_i)
		ctrl_pc_we |=> (pc[1:0] == 2'b00));

endmodule

/* logic/rv_mem_if.sv */
`timescale 1ns/1ps

interface rv_mem_if;
	import rv_pkg::*;

	word_t rd_addr;
	word_t rd_data; // Combinational answer to rd_addr
	word_t wr_addr;
	word_t wr_data;
	logic wr_enable; // One-cycle write strobe

	modport core (
		output rd_addr, wr_addr, wr_data, wr_enable,
		input rd_data
	);

	modport mem (
		input rd_addr, wr_addr, wr_data, wr_enable,
		output rd_data
	);

endinterface

/* logic/rv_pkg.sv */
`include "rv_settings.svh"

package rv_pkg;

	typedef logic [`RV_XLEN-1:0] word_t;
	typedef logic [4:0] reg_idx_t;

	typedef enum logic [6:0] {
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_BRANCH = 7'b1100011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_OP_IMM = 7'b0010011,
		OPC_OP     = 7'b0110011,
		OPC_SYSTEM = 7'b1110011 // ECALL and friends halt the core
	} opcode_t;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
		ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
		ALU_PASS2 // Operand 2 straight through, for LUI
	} alu_op_t;

	typedef enum logic [2:0] {
		CMP_EQ, CMP_NE, CMP_LT, CMP_GE, CMP_LTU, CMP_GEU
	} cmp_op_t;

	typedef enum logic [1:0] {NEXT_PC_4, NEXT_PC_ALU_OUT, NEXT_PC_BRANCH} next_pc_sel_t;

	typedef enum logic [1:0] {RF_IN_ALU_OUT, RF_IN_PC_4, RF_IN_MEM_RD} rf_in_sel_t;

	typedef enum logic {RD_ADDR_PC, RD_ADDR_ALU_OUT} rd_addr_sel_t;

	typedef enum logic {ALU_IN1_RS1, ALU_IN1_PC} alu_in1_sel_t;

	typedef enum logic [2:0] {
		ALU_IN2_RS2, ALU_IN2_IMM_I, ALU_IN2_IMM_S, ALU_IN2_IMM_B,
		ALU_IN2_IMM_U, ALU_IN2_IMM_J
	} alu_in2_sel_t;

	typedef enum logic [1:0] {ST_FETCH, ST_EXECUTE, ST_HALT} ctrl_state_t;

endpackage

/* logic/rv_regfile.sv */
`timescale 1ns/1ps
`include "rv_settings.svh"

module rv_regfile (
	input logic clk_i,
	input rv_pkg::reg_idx_t rs1_i,
	input rv_pkg::reg_idx_t rs2_i,
	input rv_pkg::reg_idx_t rd_i,
	input rv_pkg::word_t rin_i,
	input logic we_i,
	output rv_pkg::word_t rout1_o,
	output rv_pkg::word_t rout2_o
);
	import rv_pkg::*;

	word_t regs [`RV_NUM_REGS]; // Entry 0 never written

	always_ff @(posedge clk_i) begin
		if (we_i && (rd_i != '0)) begin
			regs[rd_i] <= rin_i;
		end
	end

	assign rout1_o = (rs1_i == '0) ? '0 : regs[rs1_i];
	assign rout2_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

/* logic/rv_settings.svh */
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// First fetch address after reset
`define RV_RESET_PC 32'h0001_0000

// Data and address width
`define RV_XLEN 32

// Architectural registers x0..x31
`define RV_NUM_REGS 32

`endif

/* run.sh */
#!/usr/bin/env bash
# Build the core testbench with Verilator, run it and scan the log for the verdict
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f filelist.f --top-module rv_core_tb -Mdir "$OBJ" -o rv_core_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$OBJ/rv_core_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "All checks passed" "$LOG"; then
	exit 0
fi
echo "Simulation reported failures, see $LOG"
exit 1

/* verif/rv_core_tb.sv */
`timescale 1ns/1ps
`include "rv_settings.svh"

module rv_core_tb;

	localparam int NUM_TESTS = 6;
	localparam int PROG_WORDS = 12;
	localparam int HALT_LIMIT = 400;
	localparam logic [31:0] RESULT_ADDR = `RV_RESET_PC + 32'h200;

	logic clk_i;
	logic reset_i;
	logic [31:0] mem_rd_addr;
	logic [31:0] mem_rd_data;
	logic [31:0] mem_wr_addr;
	logic [31:0] mem_wr_data;
	logic mem_wr_en;
	logic halted;
	logic load_req; // Clear memory and copy in the current program
	logic [2:0] test_idx;
	logic [31:0] mem [256];
	int pass_count;
	int fail_count;

	string name_tab [NUM_TESTS] = '{"alu_ops", "upper_imm_jumps", "branches",
		"mem_round_trip", "ecall_timing", "unknown_opcode"};

	logic [31:0] prog_tab [NUM_TESTS][PROG_WORDS] = '{
		'{32'h000100B7, 32'h06400113, 32'hFF900193, 32'h00310233, // x2=100, x3=-7
			32'h403202B3, 32'h0032C333, 32'h402353B3, 32'h0021A433,
			32'h008384B3, 32'h2090A023, 32'h00000073, 32'h00000000},
		'{32'h12345137, 32'h67810113, 32'h00001197, 32'h0080026F, // JAL skips one word
			32'h00000113, 32'h00C202E7, 32'h00000113, 32'h00310333,
			32'h00430333, 32'h00530333, 32'h1E622823, 32'h00000073},
		'{32'h00000093, 32'h00500113, 32'h00108093, 32'h00700013, // Write to x0 in loop
			32'hFE209CE3, 32'h00114463, 32'h04008093, 32'h00017463,
			32'h10008093, 32'h00000197, 32'h1C11AE23, 32'h00000073},
		'{32'h000100B7, 32'hDEADC137, 32'hEEF10113, 32'h30008193, // LW at -512 off x3
			32'h1020A023, 32'hE001A203, 32'hF041A023, 32'h00000073,
			32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000},
		'{32'h000100B7, 32'h2010A023, 32'h00000073, 32'h00000000,
			32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000,
			32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000},
		'{32'h000100B7, 32'h05500113, 32'h0000007F, 32'h2020A023, // SW never reached
			32'h00000073, 32'h00000000, 32'h00000000, 32'h00000000,
			32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000}
	};

	logic [31:0] res_addr_tab [NUM_TESTS] = '{RESULT_ADDR, RESULT_ADDR, RESULT_ADDR,
		RESULT_ADDR, RESULT_ADDR, RESULT_ADDR};
	logic [31:0] exp_tab [NUM_TESTS] = '{32'hFFFF_FFFA, 32'h1237_66A8, 32'h0000_0045,
		32'hDEAD_BEEF, 32'h0001_0000, 32'h0000_0000};
	int halt_tab [NUM_TESTS] = '{22, 20, 46, 16, 6, 6}; // Two cycles per executed instruction

	rv_core_top uut (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.mem_rd_addr_o(mem_rd_addr),
		.mem_rd_data_i(mem_rd_data),
		.mem_wr_addr_o(mem_wr_addr),
		.mem_wr_data_o(mem_wr_data),
		.mem_wr_en_o(mem_wr_en),
		.halted_o(halted)
	);

	initial begin
		clk_i = 1'b0;
		forever #5 clk_i = ~clk_i;
	end

	assign mem_rd_data = mem[mem_rd_addr[9:2]]; // Combinational read

	always @(posedge clk_i) begin
		if (load_req) begin
			for (int i = 0; i < 256; i++) begin
				mem[i[7:0]] <= (i < PROG_WORDS) ? prog_tab[test_idx][i[3:0]] : 32'h0;
			end
		end else if (mem_wr_en) begin
			mem[mem_wr_addr[9:2]] <= mem_wr_data;
		end
	end

	initial begin
		int cycles;
		int test_errors;
		logic [31:0] got;
		reset_i = 1'b1;
		load_req = 1'b0;
		test_idx = '0;
		pass_count = 0;
		fail_count = 0;
		for (int t = 0; t < NUM_TESTS; t++) begin
			test_idx = t[2:0];
			test_errors = 0;
			@(posedge clk_i);
			#1;
			reset_i = 1'b1;
			load_req = 1'b1;
			repeat (5) begin
				@(posedge clk_i);
				#1;
				load_req = 1'b0;
				if (mem_wr_en !== 1'b0) begin
					$display("CHECK FAILED %s: mem_wr_en_o in reset expected 0 actual %b",
						name_tab[test_idx], mem_wr_en);
					test_errors++;
				end
			end
			if (halted !== 1'b0) begin
				$display("CHECK FAILED %s: halted_o after reset expected 0 actual %b",
					name_tab[test_idx], halted);
				test_errors++;
			end
			reset_i = 1'b0;
			cycles = 0;
			while (halted !== 1'b1 && cycles < HALT_LIMIT) begin
				@(posedge clk_i);
				#1;
				cycles++;
			end
			if (halted !== 1'b1) begin
				$display("ERROR %s: core did not halt within %0d cycles",
					name_tab[test_idx], HALT_LIMIT);
				test_errors++;
			end else begin
				if (cycles != halt_tab[test_idx]) begin
					$display("CHECK FAILED %s: halt cycle expected %0d actual %0d",
						name_tab[test_idx], halt_tab[test_idx], cycles);
					test_errors++;
				end
				repeat (4) begin // Core must stay quiet once halted
					@(posedge clk_i);
					#1;
					if (mem_wr_en !== 1'b0) begin
						$display("CHECK FAILED %s: mem_wr_en_o after halt expected 0 actual %b",
							name_tab[test_idx], mem_wr_en);
						test_errors++;
					end
					if (halted !== 1'b1) begin
						$display("CHECK FAILED %s: halted_o expected 1 actual %b",
							name_tab[test_idx], halted);
						test_errors++;
					end
				end
			end
			got = mem[res_addr_tab[test_idx][9:2]];
			if (got !== exp_tab[test_idx]) begin
				$display("CHECK FAILED %s: word at %h expected %h actual %h",
					name_tab[test_idx], res_addr_tab[test_idx], exp_tab[test_idx], got);
				test_errors++;
			end
			if (test_errors == 0) begin
				$display("PASS %s", name_tab[test_idx]);
				pass_count++;
			end else begin
				$display("FAIL %s with %0d errors", name_tab[test_idx], test_errors);
				fail_count++;
			end
		end
		$display("Tests passed: %0d, tests failed: %0d", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule
